//--- astro_io.f
astro_cfg_pkg.sv
astro_io_pkg.sv
game_config.sv
switch_matrix.sv
audio_mix.sv
astro_io_top.sv
astro_io_asserts.sv
tb_clock.sv
astro_io_tb.sv

//--- astro_io_tb.sv
// Astrocade input and audio testbench

`timescale 1ns/10ps

module astro_io_tb;

	// One table row, expected fields filled in from the model
	typedef struct {
		string name;
		bit dl_wr;
		logic [7:0] dl_index;
		logic [astro_cfg_pkg::dl_addr_w-1:0] dl_addr;
		logic [7:0] dl_data;
		logic [7:0] col;
		logic [15:0] joy0;
		logic [15:0] joy1;
		logic votrax;
		logic [7:0] chip_l;
		logic [7:0] chip_r;
		logic [15:0] samp_l;
		logic [15:0] samp_r;
		logic speech;
		logic [7:0] exp_row;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
	} vec_t;

	logic clk_sys;
	logic reset;
	logic dl_wr;
	logic [7:0] dl_index;
	logic [astro_cfg_pkg::dl_addr_w-1:0] dl_addr;
	logic [7:0] dl_data;
	logic [7:0] col_select;
	logic [15:0] joy0;
	logic [15:0] joy1;
	logic votrax_busy;
	logic [7:0] chip_l;
	logic [7:0] chip_r;
	logic [15:0] samp_l;
	logic [15:0] samp_r;
	logic speech_sel;
	logic [7:0] row_data;
	logic [15:0] audio_l;
	logic [15:0] audio_r;

	vec_t vectors[$];
	logic [15:0] lfsr_state;
	bit table_ready;
	int error_count;

	// Configuration as the board should hold it
	logic [7:0] model_mode;
	logic [7:0] model_dip [8];

	tb_clock clock_i (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	astro_io_top dut_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_wr       (dl_wr),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.col_select  (col_select),
		.joy0        (joy0),
		.joy1        (joy1),
		.votrax_busy (votrax_busy),
		.row_data    (row_data),
		.chip_l      (chip_l),
		.chip_r      (chip_r),
		.samp_l      (samp_l),
		.samp_r      (samp_r),
		.speech_sel  (speech_sel),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	// ==================================================
	// Random source and reference model
	// ==================================================

	// Galois LFSR, one step per bit handed out
	function automatic logic [15:0] random_bits(input int count);
		logic [15:0] value;
		logic lsb;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb) lfsr_state = lfsr_state ^ 16'hB400;
			value = {value[14:0], lsb};
		end
		return value;
	endfunction

	function automatic logic random_bit();
		logic [15:0] b;
		b = random_bits(1);
		return b[0];
	endfunction

	// Download writes, DIP addresses of 8 and up are dropped
	task automatic update_model(input vec_t v);
		if (v.dl_wr && v.dl_index == astro_cfg_pkg::dl_index_mode) begin
			model_mode = v.dl_data;
		end else if (v.dl_wr && v.dl_index == astro_cfg_pkg::dl_index_dip &&
			v.dl_addr < 8) begin
			model_dip[v.dl_addr[2:0]] = v.dl_data;
		end
	endtask

	// Row byte, MSB first, buttons and stick active low
	function automatic logic [7:0] expected_row(input vec_t v);
		logic sz;
		logic gf;
		logic rr;
		logic s1;
		logic s2;
		logic c;
		logic [3:0] d1;
		logic [3:0] d2;
		sz = (model_mode == astro_cfg_pkg::mode_spacezap);
		gf = (model_mode == astro_cfg_pkg::mode_gorf) || (model_mode == astro_cfg_pkg::mode_gorf1);
		rr = (model_mode == astro_cfg_pkg::mode_robby);
		s1 = !v.joy0[6];
		s2 = !v.joy0[7];
		c = !v.joy0[8];
		d1 = ~{v.joy0[0], v.joy0[1], v.joy0[2], v.joy0[3]};
		d2 = ~{v.joy1[0], v.joy1[1], v.joy1[2], v.joy1[3]};
		if (v.col == astro_io_pkg::col_ct3) return model_dip[3];
		if (!(sz || gf || rr)) return astro_io_pkg::row_idle;
		case (v.col)
			astro_io_pkg::col_ct0: begin
				if (sz) return {1'b1, 1'b1, s2, s1, model_dip[2][1], 1'b1, c, 1'b1};
				if (gf) return {model_dip[2][2], model_dip[2][0], s2, s1, 1'b1,
					model_dip[2][1], c, 1'b1};
				return {1'b0, s2, s1, 1'b1, model_dip[2][1], 1'b1, c, 1'b1};
			end
			astro_io_pkg::col_ct1: begin
				if (sz) return {3'b111, !v.joy1[4], d2};
				if (gf) return {3'b001, !v.joy1[4], d2};
				return {2'b11, !v.joy1[4], 1'b1, d2};
			end
			astro_io_pkg::col_ct2: begin
				if (sz) return {2'b11, model_dip[2][0], !v.joy0[4], d1};
				if (gf) return {v.votrax, 2'b01, !v.joy0[4], d1};
				return {2'b11, !v.joy0[4], 1'b1, d1};
			end
			default: return astro_io_pkg::row_idle;
		endcase
	endfunction

	// Left word in the upper half, right word in the lower half
	function automatic logic [31:0] expected_audio(input vec_t v);
		logic gf;
		logic [15:0] dup_l;
		logic [15:0] dup_r;
		int mix_l;
		int mix_r;
		gf = (model_mode == astro_cfg_pkg::mode_gorf) || (model_mode == astro_cfg_pkg::mode_gorf1);
		dup_l = {v.chip_l, v.chip_l};
		dup_r = {v.chip_r, v.chip_r};
		mix_l = int'(v.chip_l) * 128 + int'(v.chip_l) / 2 + int'(v.samp_l) / 2;
		mix_r = int'(v.chip_r) * 128 + int'(v.chip_r) / 2 + int'(v.samp_r) / 2;
		if (mix_l > 65535) mix_l = 65535;
		if (mix_r > 65535) mix_r = 65535;
		if (gf && model_dip[0][0]) return {dup_l, v.speech ? v.samp_r : dup_r};
		if (gf) return {mix_l[15:0], mix_r[15:0]};
		if (model_mode == astro_cfg_pkg::mode_robby) return {dup_l, dup_r};
		return {dup_l, dup_l};
	endfunction

	// ==================================================
	// Stimulus table
	// ==================================================

	task automatic add_row(input string name, input bit wr, input logic [7:0] index,
		input logic [24:0] addr, input logic [7:0] data, input logic [7:0] col,
		input logic votrax, input logic speech, input bit loud);
		vec_t v;
		logic [31:0] audio;
		v.name = name;
		v.dl_wr = wr;
		v.dl_index = index;
		v.dl_addr = addr;
		v.dl_data = data;
		v.col = col;
		v.votrax = votrax;
		v.speech = speech;
		v.joy0 = random_bits(16);
		v.joy1 = random_bits(16);
		v.chip_l = 8'(random_bits(8));
		v.chip_r = 8'(random_bits(8));
		v.samp_l = random_bits(16);
		v.samp_r = random_bits(16);
		// Loud rows push the Gorf mix to the top of its range
		if (loud) begin
			v.chip_l = v.chip_l | 8'hF0;
			v.chip_r = v.chip_r | 8'hF0;
			v.samp_l = v.samp_l | 16'hF000;
			v.samp_r = v.samp_r | 16'hF000;
		end
		update_model(v);
		v.exp_row = expected_row(v);
		audio = expected_audio(v);
		v.exp_l = audio[31:16];
		v.exp_r = audio[15:0];
		vectors.push_back(v);
	endtask

	task automatic plain_row(input string name, input logic [7:0] col, input bit loud);
		add_row(name, 1'b0, 8'd0, 25'd0, 8'd0, col, random_bit(), random_bit(), loud);
	endtask

	task automatic load_row(input string name, input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		add_row(name, 1'b1, index, addr, data, astro_io_pkg::col_ct0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic build_table();
		logic [7:0] cols [6];
		cols = '{astro_io_pkg::col_ct0, astro_io_pkg::col_ct1, astro_io_pkg::col_ct2,
			astro_io_pkg::col_ct3, 8'h10, 8'h00};
		// No game fitted
		for (int c = 0; c < 6; c++) plain_row($sformatf("idle_col%0d", c), cols[c], 1'b0);
		// Space Zap with random DIPs
		load_row("sz_mode", astro_cfg_pkg::dl_index_mode, 25'd0, astro_cfg_pkg::mode_spacezap);
		load_row("sz_dip0", astro_cfg_pkg::dl_index_dip, 25'd0, 8'(random_bits(8)));
		load_row("sz_dip2", astro_cfg_pkg::dl_index_dip, 25'd2, 8'(random_bits(8)));
		load_row("sz_dip3", astro_cfg_pkg::dl_index_dip, 25'd3, 8'(random_bits(8)));
		for (int r = 0; r < 12; r++) plain_row($sformatf("sz_%0d", r), cols[r % 4], 1'b0);
		// Gorf then Gorf program 1, no cabinet
		load_row("gorf_dip0", astro_cfg_pkg::dl_index_dip, 25'd0, 8'(random_bits(8)) & 8'hFE);
		for (int g = 0; g < 2; g++) begin
			load_row($sformatf("gorf_mode%0d", g), astro_cfg_pkg::dl_index_mode, 25'd0,
				(g == 0) ? astro_cfg_pkg::mode_gorf : astro_cfg_pkg::mode_gorf1);
			for (int r = 0; r < 8; r++) plain_row($sformatf("gorf%0d_%0d", g, r), cols[r % 4], 1'b0);
			for (int r = 0; r < 3; r++) plain_row($sformatf("gorf%0d_loud%0d", g, r), cols[2], 1'b1);
		end
		// Cabinet wiring, speech select alternates between the two right sources
		load_row("cab_dip0", astro_cfg_pkg::dl_index_dip, 25'd0, 8'(random_bits(8)) | 8'h01);
		for (int r = 0; r < 6; r++) begin
			add_row($sformatf("cab_%0d", r), 1'b0, 8'd0, 25'd0, 8'd0, cols[r % 4], random_bit(),
				r[0], r == 5);
		end
		// Robby Roto, stray DIP writes, then an unknown mode
		load_row("rr_mode", astro_cfg_pkg::dl_index_mode, 25'd0, astro_cfg_pkg::mode_robby);
		for (int r = 0; r < 8; r++) plain_row($sformatf("rr_%0d", r), cols[r % 4], 1'b0);
		load_row("rr_dip_addr8", astro_cfg_pkg::dl_index_dip, 25'd8, 8'hA5);
		load_row("rr_dip_addr11", astro_cfg_pkg::dl_index_dip, 25'd11, 8'h5A);
		plain_row("rr_dip3_kept", cols[3], 1'b0);
		load_row("unknown_mode", astro_cfg_pkg::dl_index_mode, 25'd0, 8'd5);
		for (int c = 0; c < 6; c++) plain_row($sformatf("none_col%0d", c), cols[c], 1'b0);
	endtask

	// ==================================================
	// Apply and check
	// ==================================================

	task automatic value_error(input string test, input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		error_count++;
		$display("ERROR %s: %s expected %h actual %h", test, what, expected, actual);
		$display("Errors found");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	// Called 1 ns after an edge, strobe lasts one cycle
	task automatic run_row(input vec_t v);
		dl_wr = v.dl_wr;
		dl_index = v.dl_index;
		dl_addr = v.dl_addr;
		dl_data = v.dl_data;
		col_select = v.col;
		joy0 = v.joy0;
		joy1 = v.joy1;
		votrax_busy = v.votrax;
		chip_l = v.chip_l;
		chip_r = v.chip_r;
		samp_l = v.samp_l;
		samp_r = v.samp_r;
		speech_sel = v.speech;
		@(posedge clk_sys);
		#1;
		dl_wr = 1'b0;
		// Covers mode register, decoder and output register
		repeat (3) @(posedge clk_sys);
		#1;
		assert (row_data == v.exp_row)
			else value_error(v.name, "row_data", {8'h00, v.exp_row}, {8'h00, row_data});
		assert (audio_l == v.exp_l) else value_error(v.name, "audio_l", v.exp_l, audio_l);
		assert (audio_r == v.exp_r) else value_error(v.name, "audio_r", v.exp_r, audio_r);
	endtask

	initial begin
		dl_wr = 1'b0;
		dl_index = 8'd0;
		dl_addr = '0;
		dl_data = 8'd0;
		col_select = 8'd0;
		joy0 = 16'd0;
		joy1 = 16'd0;
		votrax_busy = 1'b0;
		chip_l = 8'd0;
		chip_r = 8'd0;
		samp_l = 16'd0;
		samp_r = 16'd0;
		speech_sel = 1'b0;
		error_count = 0;
		lfsr_state = 16'd35853;
		model_mode = astro_cfg_pkg::mode_none;
		for (int i = 0; i < 8; i++) model_dip[i] = 8'd0;
		build_table();
		table_ready = 1'b1;
		wait (reset === 1'b1);
		wait (reset === 1'b0);
		@(posedge clk_sys);
		#1;
		foreach (vectors[i]) run_row(vectors[i]);
		error_count += dut_i.asserts_i.fail_count;
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// A failing bound assertion ends the run at once
	always @(dut_i.asserts_i.fail_count) begin
		if (dut_i.asserts_i.fail_count != 0) begin
			$display("A bound assertion on the DUT failed");
			$display("Errors found");
			$fatal(1, "Assertion failure");
		end
	end

	// Watchdog, six cycles per row plus margin
	initial begin
		wait (table_ready);
		repeat (vectors.size() * 6 + 50) @(posedge clk_sys);
		$display("Watchdog expired before the test table finished");
		$display("Errors found");
		$fatal(1, "Timeout");
	end

endmodule

//--- tb_clock.sv
// Testbench clock and reset

`timescale 1ns/10ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	// 8 ns period
	localparam real half_period = 4.0;
	localparam int reset_cycles = 3;

	initial begin
		clk_sys = 1'b0;
		forever #(half_period) clk_sys = ~clk_sys;
	end

	// Release just after an edge, away from the sampling point
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk_sys);
		#1;
		reset = 1'b0;
	end

endmodule

//--- astro_io_asserts.sv
// Astrocade input and audio assertions

`timescale 1ns/10ps

module astro_io_asserts (
	input logic                             clk_sys,
	input logic                             reset,
	input logic                             is_spacezap,
	input logic                             is_gorf,
	input logic                             is_robby,
	input logic [7:0]                       row_data,
	input logic [astro_io_pkg::samp_w-1:0]  audio_l,
	input logic [astro_io_pkg::samp_w-1:0]  audio_r
);

	// Failures seen so far, read by the testbench at the end
	int fail_count = 0;

	// Game decode is one hot or all low
	flag_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({is_spacezap, is_gorf, is_robby}))
		else begin
			fail_count++;
			$error("More than one game flag is high");
		end

	// Switch matrix leaves reset with all rows released
	row_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> (row_data == astro_io_pkg::row_idle))
		else begin
			fail_count++;
			$error("Row data not idle in the first cycle after reset");
		end

	// Speakers silent during reset
	audio_in_reset: assert property (@(posedge clk_sys)
		reset |-> ((audio_l == '0) && (audio_r == '0)))
		else begin
			fail_count++;
			$error("Audio output not zero while reset is high");
		end

endmodule

// Flags from game_config are visible at the top level
bind astro_io_top astro_io_asserts asserts_i (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.is_spacezap (is_spacezap),
	.is_gorf     (is_gorf),
	.is_robby    (is_robby),
	.row_data    (row_data),
	.audio_l     (audio_l),
	.audio_r     (audio_r)
);

//--- astro_io_top.sv
// Astrocade input and audio top level

`timescale 1ns/10ps

module astro_io_top (
	input  logic                                 clk_sys,
	input  logic                                 reset,

	// Download port from the host
	input  logic                                 dl_wr,
	input  logic [7:0]                           dl_index,
	input  logic [astro_cfg_pkg::dl_addr_w-1:0]  dl_addr,
	input  logic [7:0]                           dl_data,

	// CPU switch port and players
	input  logic [7:0]                           col_select,
	input  logic [astro_io_pkg::joy_w-1:0]       joy0,
	input  logic [astro_io_pkg::joy_w-1:0]       joy1,
	input  logic                                 votrax_busy,
	output logic [7:0]                           row_data,

	// Sound sources and mixed output
	input  logic [astro_io_pkg::chip_w-1:0]      chip_l,
	input  logic [astro_io_pkg::chip_w-1:0]      chip_r,
	input  logic [astro_io_pkg::samp_w-1:0]      samp_l,
	input  logic [astro_io_pkg::samp_w-1:0]      samp_r,
	input  logic                                 speech_sel,
	output logic [astro_io_pkg::samp_w-1:0]      audio_l,
	output logic [astro_io_pkg::samp_w-1:0]      audio_r
);

	// Game flags, one hot or all low
	logic is_spacezap;
	logic is_gorf;
	logic is_robby;

	// DIP bytes used by the kept games
	logic [7:0] dip0;
	logic [7:0] dip2;
	logic [7:0] dip3;

	// ==================================================
	// Configuration
	// ==================================================

	game_config cfg_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_wr       (dl_wr),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.is_spacezap (is_spacezap),
		.is_gorf     (is_gorf),
		.is_robby    (is_robby),
		.dip0        (dip0),
		.dip2        (dip2),
		.dip3        (dip3)
	);

	// ==================================================
	// Player inputs
	// ==================================================

	switch_matrix sw_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.col_select  (col_select),
		.joy0        (joy0),
		.joy1        (joy1),
		.votrax_busy (votrax_busy),
		.is_spacezap (is_spacezap),
		.is_gorf     (is_gorf),
		.is_robby    (is_robby),
		.dip0        (dip0),
		.dip2        (dip2),
		.dip3        (dip3),
		.row_data    (row_data)
	);

	// Sound output
	audio_mix mix_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.chip_l      (chip_l),
		.chip_r      (chip_r),
		.samp_l      (samp_l),
		.samp_r      (samp_r),
		.speech_sel  (speech_sel),
		.is_spacezap (is_spacezap),
		.is_gorf     (is_gorf),
		.is_robby    (is_robby),
		.dip0        (dip0),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

endmodule

//--- audio_mix.sv
// Per-game audio routing and mix

`timescale 1ns/10ps

module audio_mix (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic [astro_io_pkg::chip_w-1:0]  chip_l,
	input  logic [astro_io_pkg::chip_w-1:0]  chip_r,
	input  logic [astro_io_pkg::samp_w-1:0]  samp_l,
	input  logic [astro_io_pkg::samp_w-1:0]  samp_r,
	input  logic                             speech_sel,
	input  logic                             is_spacezap,
	input  logic                             is_gorf,
	input  logic                             is_robby,
	input  logic [7:0]                       dip0,
	output logic [astro_io_pkg::samp_w-1:0]  audio_l,
	output logic [astro_io_pkg::samp_w-1:0]  audio_r
);

	// Chip bytes stretched to full range
	logic [astro_io_pkg::samp_w-1:0] dup_l;
	logic [astro_io_pkg::samp_w-1:0] dup_r;

	// One guard bit above the output width
	logic [astro_io_pkg::samp_w:0] work_l;
	logic [astro_io_pkg::samp_w:0] work_r;
	logic [astro_io_pkg::samp_w-1:0] sum_l;
	logic [astro_io_pkg::samp_w-1:0] sum_r;

	// Routing decodes
	logic cabinet;
	logic mono;
	logic [astro_io_pkg::samp_w-1:0] next_l;
	logic [astro_io_pkg::samp_w-1:0] next_r;

	assign dup_l = {chip_l, chip_l};
	assign dup_r = {chip_r, chip_r};

	// ==================================================
	// Gorf mixer
	// ==================================================

	// Speech is much louder than the chips, so halve the samples
	assign work_l = {2'b00, chip_l, chip_l[astro_io_pkg::chip_w-1:1]} + {2'b00, samp_l[15:1]};
	assign work_r = {2'b00, chip_r, chip_r[astro_io_pkg::chip_w-1:1]} + {2'b00, samp_r[15:1]};

	// Clip at the top instead of wrapping
	assign sum_l = work_l[astro_io_pkg::samp_w] ? astro_io_pkg::audio_max : work_l[15:0];
	assign sum_r = work_r[astro_io_pkg::samp_w] ? astro_io_pkg::audio_max : work_r[15:0];

	// ==================================================
	// Output routing
	// ==================================================

	// Upright cabinet: top speaker one chip, bottom chip or speech
	assign cabinet = is_gorf && dip0[0];
	assign mono = is_spacezap || !(is_gorf || is_robby);

	always_comb begin
		if (cabinet) begin
			next_l = dup_l;
			next_r = speech_sel ? samp_r : dup_r;
		end else if (is_gorf) begin
			next_l = sum_l;
			next_r = sum_r;
		end else if (mono) begin
			next_l = dup_l;
			next_r = dup_l;
		end else begin
			next_l = dup_l;
			next_r = dup_r;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= next_l;
			audio_r <= next_r;
		end
	end

endmodule

//--- switch_matrix.sv
// Per-game switch matrix rows

`timescale 1ns/10ps

module switch_matrix (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic [7:0]                      col_select,
	input  logic [astro_io_pkg::joy_w-1:0]  joy0,
	input  logic [astro_io_pkg::joy_w-1:0]  joy1,
	input  logic                            votrax_busy,
	input  logic                            is_spacezap,
	input  logic                            is_gorf,
	input  logic                            is_robby,
	input  logic [7:0]                      dip0,
	input  logic [7:0]                      dip2,
	input  logic [7:0]                      dip3,
	output logic [7:0]                      row_data
);

	// Active low stick nibble, right/left/down/up MSB first
	function automatic logic [3:0] stick_dirs(input logic [astro_io_pkg::joy_w-1:0] joy);
		stick_dirs = ~{joy[astro_io_pkg::joy_right], joy[astro_io_pkg::joy_left],
			joy[astro_io_pkg::joy_down], joy[astro_io_pkg::joy_up]};
	endfunction

	// Buttons inverted once, rows want them low when pressed
	logic n_s1;
	logic n_s2;
	logic n_coin;
	logic n_f1;
	logic n_f2;
	logic [3:0] dir1;
	logic [3:0] dir2;

	// Candidate rows per column and game
	logic [7:0] ct0_sz;
	logic [7:0] ct1_sz;
	logic [7:0] ct2_sz;
	logic [7:0] ct0_gf;
	logic [7:0] ct1_gf;
	logic [7:0] ct2_gf;
	logic [7:0] ct0_rr;
	logic [7:0] ct1_rr;
	logic [7:0] ct2_rr;

	// Row chosen for the current strobe
	logic [7:0] row_next;

	assign n_s1 = ~joy0[astro_io_pkg::joy_start1];
	assign n_s2 = ~joy0[astro_io_pkg::joy_start2];
	assign n_coin = ~joy0[astro_io_pkg::joy_coin];
	assign n_f1 = ~joy0[astro_io_pkg::joy_fire];
	assign n_f2 = ~joy1[astro_io_pkg::joy_fire];
	assign dir1 = stick_dirs(joy0);
	assign dir2 = stick_dirs(joy1);

	// ==================================================
	// Row layouts
	// ==================================================

	// Space Zap
	assign ct0_sz = {2'b11, n_s2, n_s1, dip2[1], 1'b1, n_coin, 1'b1};
	assign ct1_sz = {3'b111, n_f2, dir2};
	assign ct2_sz = {2'b11, dip2[0], n_f1, dir1};

	// Gorf, speech busy flag sits on top of ct2
	assign ct0_gf = {dip2[2], dip2[0], n_s2, n_s1, 1'b1, dip2[1], n_coin, 1'b1};
	assign ct1_gf = {3'b001, n_f2, dir2};
	assign ct2_gf = {votrax_busy, 2'b01, n_f1, dir1};

	// Robby Roto, spare bit between fire and stick
	assign ct0_rr = {1'b0, n_s2, n_s1, 1'b1, dip2[1], 1'b1, n_coin, 1'b1};
	assign ct1_rr = {2'b11, n_f2, 1'b1, dir2};
	assign ct2_rr = {2'b11, n_f1, 1'b1, dir1};

	// ==================================================
	// Column decode
	// ==================================================

	// ct3 is the DIP byte on every game, even none fitted
	always_comb begin
		row_next = astro_io_pkg::row_idle;
		case (col_select)
			astro_io_pkg::col_ct0: begin
				if (is_spacezap) row_next = ct0_sz;
				else if (is_gorf) row_next = ct0_gf;
				else if (is_robby) row_next = ct0_rr;
			end
			astro_io_pkg::col_ct1: begin
				if (is_spacezap) row_next = ct1_sz;
				else if (is_gorf) row_next = ct1_gf;
				else if (is_robby) row_next = ct1_rr;
			end
			astro_io_pkg::col_ct2: begin
				if (is_spacezap) row_next = ct2_sz;
				else if (is_gorf) row_next = ct2_gf;
				else if (is_robby) row_next = ct2_rr;
			end
			astro_io_pkg::col_ct3: row_next = dip3;
			default: row_next = astro_io_pkg::row_idle;
		endcase
	end

	// Registered towards the CPU read port
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			row_data <= astro_io_pkg::row_idle;
		end else begin
			row_data <= row_next;
		end
	end

endmodule

//--- game_config.sv
// Game mode and DIP switch capture

`timescale 1ns/10ps

module game_config (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 dl_wr,
	input  logic [7:0]                           dl_index,
	input  logic [astro_cfg_pkg::dl_addr_w-1:0]  dl_addr,
	input  logic [7:0]                           dl_data,
	output logic                                 is_spacezap,
	output logic                                 is_gorf,
	output logic                                 is_robby,
	output logic [7:0]                           dip0,
	output logic [7:0]                           dip2,
	output logic [7:0]                           dip3
);

	// Selected game as last downloaded
	logic [7:0] mode;

	// Full bank of DIP bytes
	logic [7:0] dip_reg [astro_cfg_pkg::dip_count];

	// Write decodes for the two download targets
	logic mode_wr;
	logic dip_wr;

	assign mode_wr = dl_wr && (dl_index == astro_cfg_pkg::dl_index_mode);

	// Addresses past the last DIP byte are dropped
	assign dip_wr = dl_wr && (dl_index == astro_cfg_pkg::dl_index_dip) &&
		(dl_addr < astro_cfg_pkg::dl_addr_w'(astro_cfg_pkg::dip_count));

	// ==================================================
	// Mode register
	// ==================================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			mode <= astro_cfg_pkg::mode_none;
		end else if (mode_wr) begin
			mode <= dl_data;
		end
	end

	// Game flags, one cycle behind the mode register
	// Gorf program 1 runs on the Gorf board logic
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			is_spacezap <= 1'b0;
			is_gorf <= 1'b0;
			is_robby <= 1'b0;
		end else begin
			is_spacezap <= (mode == astro_cfg_pkg::mode_spacezap);
			is_gorf <= (mode == astro_cfg_pkg::mode_gorf) ||
				(mode == astro_cfg_pkg::mode_gorf1);
			is_robby <= (mode == astro_cfg_pkg::mode_robby);
		end
	end

	// ==================================================
	// DIP bank
	// ==================================================

	// Low address bits pick the byte
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < astro_cfg_pkg::dip_count; i++) begin
				dip_reg[i] <= 8'd0;
			end
		end else if (dip_wr) begin
			dip_reg[dl_addr[$clog2(astro_cfg_pkg::dip_count)-1:0]] <= dl_data;
		end
	end

	// Only bytes 0, 2 and 3 feed the kept games
	assign dip0 = dip_reg[0];
	assign dip2 = dip_reg[2];
	assign dip3 = dip_reg[3];

endmodule

//--- astro_io_pkg.sv
// Astrocade player input and audio definitions

package astro_io_pkg;

	// ==================================================
	// Joystick word layout
	// ==================================================

	// Width of one joystick word from the host
	localparam int joy_w = 16;

	// Direction and fire bits, same for both sticks
	localparam logic [3:0] joy_right = 4'd0;
	localparam logic [3:0] joy_left = 4'd1;
	localparam logic [3:0] joy_down = 4'd2;
	localparam logic [3:0] joy_up = 4'd3;
	localparam logic [3:0] joy_fire = 4'd4;

	// Start buttons, both taken from stick 0
	localparam logic [3:0] joy_start1 = 4'd6;
	localparam logic [3:0] joy_start2 = 4'd7;

	// Coin slot, also on stick 0
	localparam logic [3:0] joy_coin = 4'd8;

	// ==================================================
	// Switch matrix
	// ==================================================

	// Column strobes driven by the CPU
	localparam logic [7:0] col_ct0 = 8'h01;
	localparam logic [7:0] col_ct1 = 8'h02;
	localparam logic [7:0] col_ct2 = 8'h04;
	localparam logic [7:0] col_ct3 = 8'h08;

	// All rows released (inputs are active low)
	localparam logic [7:0] row_idle = 8'hFF;

	// ==================================================
	// Audio
	// ==================================================

	// Sound chip output and sample channel widths
	localparam int chip_w = 8;
	localparam int samp_w = 16;

	// Ceiling of the unsigned output range
	localparam logic [15:0] audio_max = 16'hFFFF;

endpackage

//--- astro_cfg_pkg.sv
// Astrocade game configuration definitions

package astro_cfg_pkg;

	// ==================================================
	// Game mode codes
	// ==================================================

	// Value of the mode byte when nothing is loaded
	localparam logic [7:0] mode_none = 8'd0;

	// Space Zap, single sound chip, mono
	localparam logic [7:0] mode_spacezap = 8'd3;

	// Gorf, two chips plus speech samples
	localparam logic [7:0] mode_gorf = 8'd4;

	// Robby Roto, two chips in stereo
	localparam logic [7:0] mode_robby = 8'd6;

	// Gorf program 1, handled as plain Gorf here
	localparam logic [7:0] mode_gorf1 = 8'd7;

	// ==================================================
	// Download port
	// ==================================================

	// Index carrying the mode byte
	localparam logic [7:0] dl_index_mode = 8'd1;

	// Index carrying the DIP switch bytes
	localparam logic [7:0] dl_index_dip = 8'd254;

	// Number of DIP bytes held on the board
	localparam int dip_count = 8;

	// Byte address width of the download port
	localparam int dl_addr_w = 25;

endpackage
